//--- common/sdram_ctrl_consts.svh
// Widths and register numbers and reset timing of the SDRAM controller for every RTL and testbench file
`ifndef SDRAM_CTRL_CONSTS_SVH
`define SDRAM_CTRL_CONSTS_SVH

// The array holds 2^23 bytes as 16-bit words
`define SDRAM_DEPTH 23
`define SDRAM_COLDEPTH 8
// Row address width which is also the width of the address pins
`define SDRAM_ADRDEPTH 12
`define REFI_WIDTH 11

// CSR register numbers on csr_a
`define CSR_CTRL 3'd0
`define CSR_CMD 3'd1
`define CSR_ADR 3'd2
`define CSR_TIM 3'd3
`define CSR_REFI 3'd4

// Two cycles for tRP and tRCD with CAS latency 2 and tRFC of 8 and tWR of 2
`define TIM_RESET 16'h1412
// Refresh interval in system clock cycles
`define REFI_RESET 11'd740

`endif

//--- common/sdram_ctrl_pkg.sv
// Shared types of the SDRAM controller that the RTL and testbench import for commands and CSR words
package sdram_ctrl_pkg;

	// Command codes as the pin levels {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		MODE      = 4'b0000, // Load mode register with the address pins
		REFRESH   = 4'b0001, // Auto-refresh with every bank precharged
		PRECHARGE = 4'b0010, // A10 high closes all banks
		ACTIVE    = 4'b0011, // Opens the row on the address pins
		WRITE     = 4'b0100,
		READ      = 4'b0101,
		NOP       = 4'b0111  // Chip selected with no operation
	} sdram_cmd_e;

	typedef struct packed {
		logic [8:0] rsvd;
		logic [1:0] ba;
		logic       we_n;
		logic       cas_n;
		logic       ras_n;
		logic       cs_n;
		logic       issue; // Puts the command on the pins for one cycle
	} sdram_csr_cmd_t;

	typedef struct packed {
		logic [2:0] rsvd;
		logic [1:0] wr;  // Write recovery in cycles
		logic [3:0] rfc; // Refresh cycle time in cycles
		logic       cas; // Set for CAS latency 3 and clear for latency 2
		logic [2:0] rcd;
		logic [2:0] rp;
	} sdram_csr_tim_t;

	// One CSR write word that the bypass command register and the timing register decode
	typedef union packed {
		sdram_csr_cmd_t cmd;
		sdram_csr_tim_t tim;
	} sdram_csr_word_u;

endpackage

//--- ctlif/sdram_ctlif.sv
// CSR block of the SDRAM controller that holds control and timing and issues bypass commands for init
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_ctlif (
	input  logic                         sys_clk,
	input  logic                         rst,
	input  logic [2:0]                   csr_a,
	input  logic                         csr_we,
	input  logic [15:0]                  csr_di,
	output logic [15:0]                  csr_do,
	output logic                         bypass,    // Software owns the command pins while set
	output logic                         sdram_rst, // Holds the other blocks in reset
	output logic                         cke,
	output sdram_ctrl_pkg::sdram_cmd_e   byp_cmd,
	output logic [`SDRAM_ADRDEPTH-1:0]   byp_adr,
	output logic [1:0]                   byp_ba,
	output logic [2:0]                   tim_rp,
	output logic [2:0]                   tim_rcd,
	output logic                         tim_cas,
	output logic [`REFI_WIDTH-1:0]       tim_refi,
	output logic [3:0]                   tim_rfc,
	output logic [1:0]                   tim_wr
);
	import sdram_ctrl_pkg::*;

	localparam sdram_csr_word_u tim_rst_word = `TIM_RESET;

	sdram_csr_word_u wr_word;  // Write data seen as a command or as timing
	sdram_csr_word_u rd_word;  // Readback before the output register
	logic [3:0]      last_cmd; // Pin levels of the last issued bypass command

	assign wr_word = csr_di;

	// Readback mux for the register on csr_a
	always_comb begin
		rd_word = '0;
		case (csr_a)
			`CSR_CTRL: rd_word = {13'd0, cke, sdram_rst, bypass};
			`CSR_CMD: begin
				rd_word.cmd.ba = byp_ba;
				{rd_word.cmd.cs_n, rd_word.cmd.ras_n, rd_word.cmd.cas_n, rd_word.cmd.we_n} = last_cmd;
			end
			`CSR_ADR: rd_word = 16'(byp_adr);
			`CSR_TIM: begin
				rd_word.tim.rp = tim_rp;
				rd_word.tim.rcd = tim_rcd;
				rd_word.tim.cas = tim_cas;
				rd_word.tim.rfc = tim_rfc;
				rd_word.tim.wr = tim_wr;
			end
			`CSR_REFI: rd_word = 16'(tim_refi);
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			bypass <= 1'b1; // Power-up runs in bypass with the core in reset
			sdram_rst <= 1'b1;
			cke <= 1'b0;
			byp_cmd <= NOP;
			byp_adr <= '0;
			byp_ba <= '0;
			last_cmd <= NOP;
			tim_rp <= tim_rst_word.tim.rp;
			tim_rcd <= tim_rst_word.tim.rcd;
			tim_cas <= tim_rst_word.tim.cas;
			tim_rfc <= tim_rst_word.tim.rfc;
			tim_wr <= tim_rst_word.tim.wr;
			tim_refi <= `REFI_RESET;
			csr_do <= '0;
		end else begin
			byp_cmd <= NOP; // An issued command lasts a single cycle
			csr_do <= rd_word;
			if (csr_we) begin
				case (csr_a)
					`CSR_CTRL: begin
						bypass <= csr_di[0];
						sdram_rst <= csr_di[1];
						cke <= csr_di[2];
					end
					`CSR_CMD: begin
						byp_ba <= wr_word.cmd.ba;
						if (wr_word.cmd.issue) begin
							byp_cmd <= sdram_cmd_e'({wr_word.cmd.cs_n, wr_word.cmd.ras_n,
								wr_word.cmd.cas_n, wr_word.cmd.we_n});
							last_cmd <= {wr_word.cmd.cs_n, wr_word.cmd.ras_n,
								wr_word.cmd.cas_n, wr_word.cmd.we_n};
						end
					end
					`CSR_ADR: byp_adr <= csr_di[`SDRAM_ADRDEPTH-1:0]; // Mode word goes here
					`CSR_TIM: begin
						tim_rp <= wr_word.tim.rp;
						tim_rcd <= wr_word.tim.rcd;
						tim_cas <= wr_word.tim.cas;
						tim_rfc <= wr_word.tim.rfc;
						tim_wr <= wr_word.tim.wr;
					end
					`CSR_REFI: tim_refi <= csr_di[`REFI_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

//--- mgmt/sdram_mgmt.sv
// Management unit of the SDRAM controller that opens and closes rows and issues accesses and refresh
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_mgmt (
	input  logic                         sys_clk,
	input  logic                         sdram_rst,
	input  logic [2:0]                   tim_rp,
	input  logic [2:0]                   tim_rcd,
	input  logic [`REFI_WIDTH-1:0]       tim_refi,
	input  logic [3:0]                   tim_rfc,
	input  logic                         stb,
	input  logic                         we,
	input  logic [`SDRAM_DEPTH-2:0]      address, // Word address
	output logic                         ack,     // Pulses with the READ or WRITE command
	output logic                         read,
	output logic                         write,
	output logic [3:0]                   concerned_bank,
	input  logic                         read_safe,
	input  logic                         write_safe,
	input  logic [3:0]                   precharge_safe,
	output sdram_ctrl_pkg::sdram_cmd_e   cmd,
	output logic [`SDRAM_ADRDEPTH-1:0]   adr,
	output logic [1:0]                   ba
);
	import sdram_ctrl_pkg::*;

	localparam logic [3:0] s_idle = 4'd0;
	localparam logic [3:0] s_pre = 4'd1;    // Closes the wrong row of the bank
	localparam logic [3:0] s_trp = 4'd2;
	localparam logic [3:0] s_act = 4'd3;
	localparam logic [3:0] s_trcd = 4'd4;
	localparam logic [3:0] s_rdwr = 4'd5;   // Waits for the data path then issues the access
	localparam logic [3:0] s_preall = 4'd6; // Refresh starts by closing every bank
	localparam logic [3:0] s_rtrp = 4'd7;
	localparam logic [3:0] s_ref = 4'd8;
	localparam logic [3:0] s_trfc = 4'd9;

	logic [3:0]                 state;
	logic [3:0]                 state_next;
	logic [3:0]                 wait_cnt; // Counts down tRP or tRCD or tRFC
	logic                       wait_load;
	logic [3:0]                 wait_val;
	logic [`REFI_WIDTH-1:0]     refi_cnt;
	logic                       refresh_pending;
	logic [3:0]                 has_open; // One bit per bank with an open row
	logic [`SDRAM_ADRDEPTH-1:0] open_row [4];
	logic [`SDRAM_COLDEPTH-1:0] col;
	logic [1:0]                 bank;
	logic [`SDRAM_ADRDEPTH-1:0] row;

	// Word address splits into row then bank then column
	assign col = address[`SDRAM_COLDEPTH-1:0];
	assign bank = address[`SDRAM_COLDEPTH+1:`SDRAM_COLDEPTH];
	assign row = address[`SDRAM_DEPTH-2:`SDRAM_COLDEPTH+2];
	assign concerned_bank = 4'b0001 << bank;

	always_comb begin
		state_next = state;
		cmd = NOP;
		adr = '0;
		ba = bank;
		read = 1'b0;
		write = 1'b0;
		ack = 1'b0;
		wait_load = 1'b0;
		wait_val = '0;
		case (state)
			s_idle: begin
				if (refresh_pending) // Refresh wins between accesses
					state_next = s_preall;
				else if (stb && !has_open[bank])
					state_next = s_act;
				else if (stb && open_row[bank] == row)
					state_next = s_rdwr; // Row hit goes straight to the access
				else if (stb)
					state_next = s_pre;
			end
			s_pre: begin
				if (precharge_safe[bank]) begin // Write recovery has passed
					cmd = PRECHARGE;
					wait_load = 1'b1;
					wait_val = {1'b0, tim_rp};
					state_next = s_trp;
				end
			end
			s_trp: if (wait_cnt == '0) state_next = s_act;
			s_act: begin
				cmd = ACTIVE;
				adr = row;
				wait_load = 1'b1;
				wait_val = {1'b0, tim_rcd};
				state_next = s_trcd;
			end
			s_trcd: if (wait_cnt == '0) state_next = s_rdwr;
			s_rdwr: begin
				if (we && write_safe) begin
					cmd = WRITE;
					write = 1'b1;
				end else if (!we && read_safe) begin
					cmd = READ;
					read = 1'b1;
				end
				if (we ? write_safe : read_safe) begin
					adr[`SDRAM_COLDEPTH-1:0] = col; // A10 low so the row stays open
					ack = 1'b1;
					state_next = s_idle;
				end
			end
			s_preall: begin
				if (&precharge_safe) begin
					cmd = PRECHARGE;
					adr[10] = 1'b1; // All banks
					wait_load = 1'b1;
					wait_val = {1'b0, tim_rp};
					state_next = s_rtrp;
				end
			end
			s_rtrp: if (wait_cnt == '0) state_next = s_ref;
			s_ref: begin
				cmd = REFRESH;
				wait_load = 1'b1;
				wait_val = tim_rfc;
				state_next = s_trfc;
			end
			s_trfc: if (wait_cnt == '0) state_next = s_idle; // No access inside tRFC
			default: state_next = s_idle;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state <= s_idle;
			wait_cnt <= '0;
			refi_cnt <= tim_refi;
			refresh_pending <= 1'b0;
			has_open <= '0; // All banks are closed by the init sequence
		end else begin
			state <= state_next;
			if (wait_load)
				wait_cnt <= wait_val;
			else if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 4'd1;
			if (cmd == REFRESH)
				refresh_pending <= 1'b0;
			if (refi_cnt == '0) begin // Interval expired so a refresh is due
				refi_cnt <= tim_refi;
				refresh_pending <= 1'b1;
			end else begin
				refi_cnt <= refi_cnt - 1'b1;
			end
			if (cmd == PRECHARGE)
				has_open <= adr[10] ? 4'b0000 : has_open & ~concerned_bank;
			else if (cmd == ACTIVE)
				has_open <= has_open | concerned_bank;
		end
	end

	// Row of each bank as it was opened
	always_ff @(posedge sys_clk) begin
		if (cmd == ACTIVE)
			open_row[bank] <= row;
	end

endmodule

//--- verilog/sdram_busif.sv
// Bus front end of the SDRAM controller that turns an FML strobe into one management request
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_busif (
	input  logic                    sys_clk,
	input  logic                    sdram_rst,
	input  logic [`SDRAM_DEPTH-1:0] fml_adr, // Byte address
	input  logic                    fml_stb,
	input  logic                    fml_we,
	output logic                    fml_ack,
	output logic                    mgmt_stb,
	output logic                    mgmt_we,
	output logic [`SDRAM_DEPTH-2:0] mgmt_address,
	input  logic                    mgmt_ack,
	input  logic                    data_ack
);
	logic busy; // Command is out and its data phase is still running

	assign mgmt_address = fml_adr[`SDRAM_DEPTH-1:1]; // Words are 16 bits wide
	assign mgmt_we = fml_we;
	assign mgmt_stb = fml_stb & ~busy; // A held strobe is requested only once
	assign fml_ack = data_ack; // The bus ends when the data is done

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			busy <= 1'b0;
		else if (mgmt_ack)
			busy <= 1'b1;
		else if (data_ack)
			busy <= 1'b0; // A new access may start in the next cycle
	end

endmodule

//--- verilog/sdram_datactl.sv
// Data path timing of the SDRAM controller that spaces reads and writes and acknowledges data
`timescale 1ns/1ps

module sdram_datactl (
	input  logic       sys_clk,
	input  logic       sdram_rst,
	input  logic       read,  // READ leaves the management unit in this cycle
	input  logic       write, // WRITE leaves the management unit in this cycle
	input  logic [3:0] concerned_bank,
	output logic       read_safe,
	output logic       write_safe,
	output logic [3:0] precharge_safe,
	output logic       ack,
	output logic       direction,   // High in the cycle the write data is registered
	output logic       direction_r, // High while the pins drive DQ
	input  logic       tim_cas,
	input  logic [1:0] tim_wr
);
	logic [3:0] rd_sr;  // Read commands delayed by one to four cycles
	logic [2:0] rd_cnt; // Cycles until read data has left the bus
	logic [2:0] wr_cnt [4];

	assign direction = write;
	assign write_safe = (rd_cnt == 3'd0);
	assign read_safe = ~direction_r; // Keeps one idle cycle after a write

	always_comb begin
		for (int b = 0; b < 4; b++)
			precharge_safe[b] = (wr_cnt[b] == 3'd0);
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			rd_sr <= '0;
			rd_cnt <= '0;
			ack <= 1'b0;
			direction_r <= 1'b0;
			for (int b = 0; b < 4; b++)
				wr_cnt[b] <= '0;
		end else begin
			rd_sr <= {rd_sr[2:0], read};
			// Pin register then CAS latency then capture register
			ack <= write | (tim_cas ? rd_sr[3] : rd_sr[2]);
			direction_r <= direction;
			if (read)
				rd_cnt <= tim_cas ? 3'd4 : 3'd3;
			else if (rd_cnt != 3'd0)
				rd_cnt <= rd_cnt - 3'd1;
			for (int b = 0; b < 4; b++) begin
				if (write && concerned_bank[b])
					wr_cnt[b] <= {1'b0, tim_wr} + 3'd1; // Write recovery starts at the pins
				else if (wr_cnt[b] != 3'd0)
					wr_cnt[b] <= wr_cnt[b] - 3'd1;
			end
		end
	end

endmodule

//--- verilog/sdram_io.sv
// Pin stage of the SDRAM controller that selects bypass or management commands and registers all pins
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_io (
	input  logic                         sys_clk,
	input  logic                         bypass,
	input  logic                         cke,
	input  sdram_ctrl_pkg::sdram_cmd_e   byp_cmd,
	input  logic [`SDRAM_ADRDEPTH-1:0]   byp_adr,
	input  logic [1:0]                   byp_ba,
	input  sdram_ctrl_pkg::sdram_cmd_e   mgmt_cmd,
	input  logic [`SDRAM_ADRDEPTH-1:0]   mgmt_adr,
	input  logic [1:0]                   mgmt_ba,
	input  logic                         direction,
	input  logic                         direction_r,
	input  logic [1:0]                   mo,   // Byte enables from the bus
	input  logic [15:0]                  dout, // Write data from the bus
	output logic [15:0]                  di,   // Captured read data
	output logic                         sdram_cke,
	output logic                         sdram_cs_n,
	output logic                         sdram_ras_n,
	output logic                         sdram_cas_n,
	output logic                         sdram_we_n,
	output logic [`SDRAM_ADRDEPTH-1:0]   sdram_adr,
	output logic [1:0]                   sdram_ba,
	output logic [1:0]                   sdram_dqm,
	inout  wire  [15:0]                  sdram_dq
);
	logic [3:0]  cmd_mux; // Command pin levels before the pin register
	logic [15:0] dq_out;

	assign cmd_mux = bypass ? byp_cmd : mgmt_cmd;
	assign sdram_dq = direction_r ? dq_out : 'z; // Driven only in the write cycle

	// Every pin leaves through a register so it can sit in the IO cell
	always_ff @(posedge sys_clk) begin
		sdram_cke <= cke; // Always under software control
		{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= cmd_mux;
		sdram_adr <= bypass ? byp_adr : mgmt_adr;
		sdram_ba <= bypass ? byp_ba : mgmt_ba;
		sdram_dqm <= direction ? ~mo : 2'b00; // DQM masks where the select is low
		if (direction)
			dq_out <= dout;
		di <= sdram_dq;
	end

endmodule

//--- verilog/sdram_ctrl.sv
// Top level of the 16-bit SDRAM controller that wires the CSR, management, bus, data and pin blocks
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_ctrl (
	input  logic                       sys_clk,
	input  logic                       rst,
	input  logic [2:0]                 csr_a,
	input  logic                       csr_we,
	input  logic [15:0]                csr_di,
	output logic [15:0]                csr_do,
	input  logic [`SDRAM_DEPTH-1:0]    fml_adr,
	input  logic                       fml_stb,
	input  logic                       fml_we,
	input  logic [1:0]                 fml_sel,
	input  logic [15:0]                fml_di,
	output logic                       fml_ack,
	output logic [15:0]                fml_do,
	output logic                       sdram_cke, // The SDRAM clock comes from outside
	output logic                       sdram_cs_n,
	output logic                       sdram_ras_n,
	output logic                       sdram_cas_n,
	output logic                       sdram_we_n,
	output logic [`SDRAM_ADRDEPTH-1:0] sdram_adr,
	output logic [1:0]                 sdram_ba,
	output logic [1:0]                 sdram_dqm,
	inout  wire  [15:0]                sdram_dq
);
	import sdram_ctrl_pkg::*;

	logic                       bypass, sdram_rst, cke;
	sdram_cmd_e                 byp_cmd, mgmt_cmd;
	logic [`SDRAM_ADRDEPTH-1:0] byp_adr, mgmt_adr;
	logic [1:0]                 byp_ba, mgmt_ba;
	logic [2:0]                 tim_rp, tim_rcd;
	logic                       tim_cas;
	logic [`REFI_WIDTH-1:0]     tim_refi;
	logic [3:0]                 tim_rfc;
	logic [1:0]                 tim_wr;
	logic                       mgmt_stb, mgmt_we, mgmt_ack;
	logic [`SDRAM_DEPTH-2:0]    mgmt_address;
	logic                       read, write, read_safe, write_safe;
	logic [3:0]                 concerned_bank, precharge_safe;
	logic                       data_ack, direction, direction_r;

	sdram_ctlif ctlif (.*);

	sdram_mgmt mgmt (
		.stb(mgmt_stb),
		.we(mgmt_we),
		.address(mgmt_address),
		.ack(mgmt_ack),
		.cmd(mgmt_cmd),
		.adr(mgmt_adr),
		.ba(mgmt_ba),
		.*
	);

	sdram_busif busif (.*);

	sdram_datactl datactl (
		.ack(data_ack),
		.*
	);

	// The pin block turns the bus byte selects into DQM
	sdram_io io (
		.mo(fml_sel),
		.dout(fml_di),
		.di(fml_do),
		.*
	);

endmodule

//--- tb/sdram_ctrl_props.sv
// Bus handshake and row state checks of the SDRAM controller, bound to its top level by the testbench
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_ctrl_props (
	input logic                       sys_clk,
	input logic                       rst,
	input logic                       bypass,
	input logic                       fml_stb,
	input logic                       fml_ack,
	input logic                       sdram_cs_n,
	input logic                       sdram_ras_n,
	input logic                       sdram_cas_n,
	input logic                       sdram_we_n,
	input logic [`SDRAM_ADRDEPTH-1:0] sdram_adr,
	input logic [1:0]                 sdram_ba
);
	import sdram_ctrl_pkg::*;

	sdram_cmd_e  pin_cmd;
	logic [3:0]  row_open;       // Banks activated and not precharged since
	int unsigned fail_count = 0; // Failed assertions so far

	assign pin_cmd = sdram_cmd_e'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

	// Row state as the SDRAM sees it on the pins
	always_ff @(posedge sys_clk) begin
		if (rst)
			row_open <= '0;
		else if (pin_cmd == ACTIVE)
			row_open[sdram_ba] <= 1'b1;
		else if (pin_cmd == PRECHARGE)
			row_open <= sdram_adr[10] ? 4'b0000 : row_open & ~(4'b0001 << sdram_ba);
	end

	ack_needs_stb: assert property (@(posedge sys_clk) disable iff (rst) fml_ack |-> fml_stb)
		else begin
			$error("fml_ack while fml_stb is low");
			fail_count++;
		end

	no_ack_in_bypass: assert property (@(posedge sys_clk) disable iff (rst) bypass |-> !fml_ack)
		else begin
			$error("fml_ack while the pins are in bypass");
			fail_count++;
		end

	// READ and WRITE only reach a bank whose row is open
	access_open_row: assert property (@(posedge sys_clk) disable iff (rst)
		(pin_cmd == READ || pin_cmd == WRITE) |-> row_open[sdram_ba])
		else begin
			$error("READ or WRITE to bank %0d with no open row", sdram_ba);
			fail_count++;
		end

endmodule

//--- tb/sdram_ctrl_tb.sv
// Testbench of the SDRAM controller with a behavioural SDRAM, compiled from the file list in the root
`timescale 1ns/1ps
`include "sdram_ctrl_consts.svh"

module sdram_ctrl_tb;
	import sdram_ctrl_pkg::*;

	localparam int rfc_cycles = 8; // tRFC of the reset timing word

	logic                       sys_clk = 1'b0;
	logic                       rst;
	logic [2:0]                 csr_a;
	logic                       csr_we;
	logic [15:0]                csr_di, csr_do;
	logic [`SDRAM_DEPTH-1:0]    fml_adr;
	logic                       fml_stb, fml_we, fml_ack;
	logic [1:0]                 fml_sel;
	logic [15:0]                fml_di, fml_do;
	logic                       sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
	logic [`SDRAM_ADRDEPTH-1:0] sdram_adr;
	logic [1:0]                 sdram_ba, sdram_dqm;
	wire  [15:0]                sdram_dq;

	sdram_cmd_e                 pin_cmd;
	logic [15:0]                mem [logic [21:0]];    // SDRAM array keyed by bank, row, column
	logic [15:0]                shadow [logic [21:0]]; // Expected contents keyed by word address
	logic [`SDRAM_ADRDEPTH-1:0] row_of [4];            // Open row of each bank in the model
	logic [2:0]                 cl = 3'd2;             // CAS latency from the last MODE command
	logic [16:0]                rd_slot [4] = '{default: '0}; // Valid bit and read word per cycle
	logic                       dq_oe = 1'b0;
	logic [15:0]                dq_val = '0;
	int                         since_ref = 1000; // Cycles since the model saw REFRESH
	int                         ref_count = 0;
	int                         errors = 0;
	int                         timeouts = 0;
	integer                     seed = 32'h2e3b_dac5;

	assign pin_cmd = sdram_cmd_e'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});
	assign sdram_dq = dq_oe ? dq_val : 'z;

	always #20 sys_clk = ~sys_clk;

	sdram_ctrl DUT (.*);

	bind sdram_ctrl sdram_ctrl_props props (.*);

	// The SDRAM samples its pins on the rising edge like the real device
	always @(posedge sys_clk) begin
		logic [21:0] key;
		logic [15:0] word;
		since_ref++;
		for (int i = 0; i < 3; i++)
			rd_slot[i] = rd_slot[i + 1];
		rd_slot[3] = '0;
		key = {sdram_ba, row_of[sdram_ba], sdram_adr[`SDRAM_COLDEPTH-1:0]};
		case (pin_cmd)
			ACTIVE: row_of[sdram_ba] = sdram_adr;
			MODE: cl = sdram_adr[6:4]; // Latency field of the mode word
			REFRESH: begin
				since_ref = 0;
				ref_count++;
			end
			WRITE: begin
				word = mem.exists(key) ? mem[key] : 16'h0000;
				if (!sdram_dqm[0]) word[7:0] = sdram_dq[7:0]; // DQM high masks the byte
				if (!sdram_dqm[1]) word[15:8] = sdram_dq[15:8];
				mem[key] = word;
			end
			READ: rd_slot[cl - 3'd1] = {1'b1, mem.exists(key) ? mem[key] : 16'h0000};
			default: ;
		endcase
		if (pin_cmd == READ || pin_cmd == WRITE)
			assert (since_ref > rfc_cycles) else begin
				errors++;
				$display("Access issued only %0d cycles after a REFRESH", since_ref);
			end
		dq_oe <= rd_slot[0][16]; // Data is stable across the sampling edge
		dq_val <= rd_slot[0][15:0];
	end

	task automatic expect_equal(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic csr_write(input logic [2:0] a, input logic [15:0] d);
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	// csr_do follows the address one cycle later
	task automatic csr_check(input logic [2:0] a, input logic [15:0] exp);
		csr_a = a;
		@(negedge sys_clk);
		expect_equal($sformatf("csr_do[%0d]", a), csr_do, exp);
	endtask

	function automatic sdram_csr_word_u cmd_word(input sdram_cmd_e cmd, input logic [1:0] ba,
			input logic issue);
		sdram_csr_word_u w;
		w = '0;
		{w.cmd.cs_n, w.cmd.ras_n, w.cmd.cas_n, w.cmd.we_n} = cmd;
		w.cmd.ba = ba;
		w.cmd.issue = issue;
		return w;
	endfunction

	// CSR register then pin register puts the command out two cycles after the write
	task automatic bypass_issue(input sdram_cmd_e cmd, input logic [1:0] ba);
		csr_write(`CSR_CMD, cmd_word(cmd, ba, 1'b1));
		expect_equal("sdram_cmd", pin_cmd, NOP);
		@(negedge sys_clk);
		expect_equal("sdram_cmd", pin_cmd, cmd);
		expect_equal("sdram_ba", sdram_ba, ba);
		@(negedge sys_clk);
		expect_equal("sdram_cmd", pin_cmd, NOP); // Only one cycle wide
		csr_check(`CSR_CMD, cmd_word(cmd, ba, 1'b0));
	endtask

	task automatic bus_access(input logic we, input logic [21:0] wadr, input logic [1:0] sel,
			input logic [15:0] d, output logic [15:0] q);
		int t;
		fml_adr = {wadr, 1'b0};
		fml_we = we;
		fml_sel = sel;
		fml_di = d;
		fml_stb = 1'b1;
		t = 0;
		do begin
			@(negedge sys_clk);
			t++;
		end while (!fml_ack && t < 200);
		q = fml_do; // Read data is valid in the ack cycle
		if (!fml_ack) begin
			timeouts++;
			$display("Timeout waiting for fml_ack at word address %h", wadr);
		end
		@(negedge sys_clk);
		fml_stb = 1'b0;
	endtask

	// Few rows and columns per bank so row misses and rewrites happen often
	task automatic random_pass(input int n);
		logic [21:0] wadr;
		logic [15:0] d, q, old;
		logic [1:0]  sel;
		for (int i = 0; i < n; i++) begin
			wadr = {10'd0, 2'($random(seed)), 2'($random(seed)), 5'd0, 3'($random(seed))};
			d = 16'($random(seed));
			sel = 2'($random(seed));
			old = shadow.exists(wadr) ? shadow[wadr] : 16'h0000;
			shadow[wadr] = {sel[1] ? d[15:8] : old[15:8], sel[0] ? d[7:0] : old[7:0]};
			bus_access(1'b1, wadr, sel, d, q);
		end
		foreach (shadow[a]) begin
			bus_access(1'b0, a, 2'b11, 16'h0000, q);
			expect_equal("fml_do", q, shadow[a]);
		end
	endtask

	initial begin
		logic [15:0]     q;
		sdram_csr_word_u tw;
		int              start;
		int              t;
		rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		fml_adr = '0;
		fml_stb = 1'b0;
		fml_we = 1'b0;
		fml_sel = '0;
		fml_di = '0;
		repeat (4) @(negedge sys_clk);
		rst = 1'b0;
		expect_equal("sdram_cmd", pin_cmd, NOP);
		expect_equal("sdram_cke", sdram_cke, 1'b0);
		expect_equal("fml_ack", fml_ack, 1'b0);
		csr_check(`CSR_CTRL, 16'h0003); // Bypass with the core in reset
		csr_check(`CSR_CMD, cmd_word(NOP, 2'd0, 1'b0));
		csr_check(`CSR_ADR, 16'h0000);
		csr_check(`CSR_TIM, `TIM_RESET);
		csr_check(`CSR_REFI, 16'(`REFI_RESET));
		csr_write(`CSR_CTRL, 16'h0007);
		csr_check(`CSR_CTRL, 16'h0007);
		expect_equal("sdram_cke", sdram_cke, 1'b1); // Pin register follows the control bit
		csr_write(`CSR_ADR, 16'h0A5C);
		csr_check(`CSR_ADR, 16'h0A5C);
		csr_write(`CSR_TIM, 16'h0AD9);
		csr_check(`CSR_TIM, 16'h0AD9);
		csr_write(`CSR_TIM, `TIM_RESET);
		csr_write(`CSR_REFI, 16'd700);
		csr_check(`CSR_REFI, 16'd700);

		// Power-up sequence by software
		csr_write(`CSR_ADR, 16'h0400); // A10 closes every bank
		bypass_issue(PRECHARGE, 2'd0);
		bypass_issue(REFRESH, 2'd0);
		bypass_issue(REFRESH, 2'd0);
		csr_write(`CSR_ADR, 16'h0020); // Burst length 1 and CAS latency 2
		bypass_issue(MODE, 2'd0);
		csr_write(`CSR_CTRL, 16'h0004);
		csr_check(`CSR_CTRL, 16'h0004);

		bus_access(1'b1, 22'h012345, 2'b11, 16'hBEEF, q);
		bus_access(1'b0, 22'h012345, 2'b11, 16'h0000, q);
		expect_equal("fml_do", q, 16'hBEEF);
		random_pass(24);

		// Back to bypass to load CAS latency 3 with the banks closed
		csr_write(`CSR_CTRL, 16'h0007);
		csr_write(`CSR_ADR, 16'h0400);
		bypass_issue(PRECHARGE, 2'd0);
		csr_write(`CSR_ADR, 16'h0030);
		bypass_issue(MODE, 2'd0);
		tw = `TIM_RESET;
		tw.tim.cas = 1'b1;
		csr_write(`CSR_TIM, tw);
		csr_write(`CSR_CTRL, 16'h0004);
		random_pass(24);

		start = ref_count;
		csr_write(`CSR_REFI, 16'd40);
		t = 0;
		while (ref_count < start + 3 && t < 3000) begin
			@(negedge sys_clk);
			t++;
		end
		if (ref_count < start + 3) begin
			timeouts++;
			$display("Timeout waiting for REFRESH commands while the bus is idle");
		end
		random_pass(8); // Accesses now meet frequent refreshes

		@(negedge sys_clk);
		$display("errors: %0d checks, %0d timeouts, %0d properties", errors, timeouts,
			DUT.props.fail_count);
		if (errors == 0 && timeouts == 0 && DUT.props.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+common
common/sdram_ctrl_pkg.sv
ctlif/sdram_ctlif.sv
mgmt/sdram_mgmt.sv
verilog/sdram_busif.sv
verilog/sdram_datactl.sv
verilog/sdram_io.sv
verilog/sdram_ctrl.sv
tb/sdram_ctrl_props.sv
tb/sdram_ctrl_tb.sv

//--- Bender.yml
package:
  name: sdram_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/sdram_ctrl_pkg.sv
      - ctlif/sdram_ctlif.sv
      - mgmt/sdram_mgmt.sv
      - verilog/sdram_busif.sv
      - verilog/sdram_datactl.sv
      - verilog/sdram_io.sv
      - verilog/sdram_ctrl.sv
      - tb/sdram_ctrl_props.sv
      - tb/sdram_ctrl_tb.sv
